// ==== flist.f ====
+incdir+verif
verilog/rx_queue_pkg.sv
verilog/rx_fsm_pkg.sv
verilog/rx_sync_fifo.sv
verilog/rx_mac_capture.sv
verilog/rx_output_ctrl.sv
verilog/rx_queue_regs.sv
verilog/rx_queue.sv
verif/rx_queue_tb.sv

// ==== verif/rx_frame_model.svh ====
// reference model of the queue output
// header word, big-endian data words, last-lane marker
`ifndef RX_FRAME_MODEL_SVH
`define RX_FRAME_MODEL_SVH

// whole words needed for len bytes
function automatic pkt_len_t words_for(input int len);
   return pkt_len_t'((len + BYTES_PER_WORD - 1) / BYTES_PER_WORD);
endfunction

// module header: word count, source port, byte count
function automatic word_t header_word(input int len);
   word_t h;
   h = '0;
   h[HDR_WORD_LEN_POS +: $bits(pkt_len_t)]  = words_for(len);
   h[HDR_SRC_PORT_POS +: $bits(port_num_t)] = PORT_NUMBER;
   h[HDR_BYTE_LEN_POS +: $bits(pkt_len_t)]  = pkt_len_t'(len);
   return h;
endfunction

// one bit at the lane of the last byte, byte 0 sits in the top lane
function automatic ctrl_t last_marker(input int len);
   int lane;
   lane = (len - 1) % BYTES_PER_WORD;
   return ctrl_t'(1) << (BYTES_PER_WORD - 1 - lane);
endfunction

// queue up header plus data words of the frame held in frame_buf
function automatic void expected_frame_words(input int len, input string name);
   word_t w;
   int    nw;
   nw = int'(words_for(len));
   exp_data.push_back(header_word(len));
   exp_ctrl.push_back(STAGE_NUMBER);       // header carries the stage
   exp_name.push_back(name);
   for (int i = 0; i < nw; i++) begin
      w = '0;                              // tail lanes stay zero
      for (int j = 0; j < BYTES_PER_WORD; j++) begin
         if (i * BYTES_PER_WORD + j < len)
            w[(BYTES_PER_WORD - 1 - j) * 8 +: 8] = frame_buf[i * BYTES_PER_WORD + j];
      end
      exp_data.push_back(w);
      exp_ctrl.push_back((i == nw - 1) ? last_marker(len) : '0);
      exp_name.push_back(name);
   end
endfunction

`endif

// ==== verif/rx_queue_tb.sv ====
// testbench for the receive queue
// clock, frame stimulus, output compare, counter checks, watchdog
`timescale 1ns/1ns
`default_nettype none

module rx_queue_tb;
   import rx_queue_pkg::*;

   localparam int        MAX_PKT_BYTES  = 256;
   localparam int        BUF_DEPTH_BITS = 7;
   localparam port_num_t PORT_NUMBER    = 16'h0003;
   localparam ctrl_t     STAGE_NUMBER   = 8'h2a;
   localparam int        BUF_WORDS      = 2 ** BUF_DEPTH_BITS;
   localparam int        MAX_WORDS      = MAX_PKT_BYTES / BYTES_PER_WORD;
   localparam int        NUM_FRAMES     = 38;   // all frames of all tests
   localparam int        WATCHDOG_NS    = NUM_FRAMES * (MAX_PKT_BYTES + 40) * 8 * 4;

   logic  clk;
   logic  reset;
   byte_t gmac_rx_data;
   logic  gmac_rx_dvld;
   logic  gmac_rx_goodframe;
   logic  gmac_rx_badframe;
   logic  cfg_wr;
   logic  cfg_enable;
   logic  out_rdy;
   logic  out_wr;
   word_t out_data;
   ctrl_t out_ctrl;
   cnt_t  good_cnt, bad_cnt, dropped_cnt, pulled_cnt;

   integer seed;
   integer rdy_seed;                    // own stream for out_rdy
   int     errors;
   int     words_checked;
   string  test_name;
   logic   rdy_random;                  // out_rdy from $random
   logic   rdy_level;                   // otherwise this level
   int     exp_good, exp_bad, exp_dropped;
   byte_t  frame_buf [MAX_PKT_BYTES + 40];
   word_t  exp_data [$];                // predicted output in arrival order
   ctrl_t  exp_ctrl [$];
   string  exp_name [$];                // test that queued each word

   `include "rx_frame_model.svh"

   rx_queue #(
      .MAX_PKT_BYTES   (MAX_PKT_BYTES),
      .BUF_DEPTH_BITS  (BUF_DEPTH_BITS),
      .STAT_DEPTH_BITS (5),
      .PORT_NUMBER     (PORT_NUMBER),
      .STAGE_NUMBER    (STAGE_NUMBER)
   ) dut0 (
      .clk (clk), .reset (reset),
      .gmac_rx_data (gmac_rx_data), .gmac_rx_dvld (gmac_rx_dvld),
      .gmac_rx_goodframe (gmac_rx_goodframe), .gmac_rx_badframe (gmac_rx_badframe),
      .cfg_wr (cfg_wr), .cfg_enable (cfg_enable),
      .out_data (out_data), .out_ctrl (out_ctrl), .out_wr (out_wr), .out_rdy (out_rdy),
      .good_cnt (good_cnt), .bad_cnt (bad_cnt),
      .dropped_cnt (dropped_cnt), .pulled_cnt (pulled_cnt)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;              // 8 ns period
   end

   function automatic int rand_below(input int n);
      integer r;
      r = $random(seed);
      return int'($unsigned(r) % n);
   endfunction

   // ========================================================================
   // checks
   // ========================================================================
   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: out_data expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: out_ctrl expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input cnt_t exp, input cnt_t act);
      if (act !== exp) begin
         errors++;
         $display("FAIL %s: expected %0d actual %0d", name, exp, act);
      end
   endtask

   // every transferred word against the model
   always @(posedge clk) begin : compare_out
      word_t w;
      ctrl_t c;
      string n;
      logic  rdy_prev;                    // out_rdy in the cycle that raised out_wr
      if (!reset && out_wr === 1'b1) begin
         if (rdy_prev !== 1'b1) begin
            errors++;
            $display("ERROR %s: DUT sent a word although the sink was not ready",
                     test_name);
         end
         if (exp_data.size() == 0) begin
            errors++;
            $display("ERROR %s: DUT sent word %h that no frame accounts for",
                     test_name, out_data);
         end else begin
            w = exp_data.pop_front();
            c = exp_ctrl.pop_front();
            n = exp_name.pop_front();
            check_word(n, w, out_data);
            check_ctrl(n, c, out_ctrl);
            words_checked++;
         end
      end
      rdy_prev = out_rdy;
   end

   // sink ready either random or held at rdy_level
   always @(posedge clk) begin : drive_rdy
      integer r;
      r = $random(rdy_seed);
      out_rdy <= rdy_random ? r[0] : rdy_level;
   end

   // ========================================================================
   // stimulus
   // ========================================================================
   task automatic write_enable(input logic en);
      @(posedge clk);
      cfg_wr     <= 1'b1;
      cfg_enable <= en;
      @(posedge clk);
      cfg_wr     <= 1'b0;
   endtask

   // predict the outcome and play the frame on the mac inputs
   task automatic send_frame(input int len, input logic good_fcs, input logic admitted);
      for (int i = 0; i < len; i++) begin
         frame_buf[i] = byte_t'($random(seed));
      end
      if (!admitted) exp_dropped++;
      else if (len > MAX_PKT_BYTES || !good_fcs) exp_bad++;   // cut off or fcs error
      else begin
         exp_good++;
         expected_frame_words(len, test_name);
      end
      for (int i = 0; i < len; i++) begin
         @(posedge clk);
         gmac_rx_data <= frame_buf[i];
         gmac_rx_dvld <= 1'b1;
      end
      @(posedge clk);
      gmac_rx_dvld <= 1'b0;
      gmac_rx_data <= '0;
      repeat (3) @(posedge clk);            // fcs verdict comes late
      gmac_rx_goodframe <= good_fcs;
      gmac_rx_badframe  <= !good_fcs;
      @(posedge clk);
      gmac_rx_goodframe <= 1'b0;
      gmac_rx_badframe  <= 1'b0;
      repeat (4) @(posedge clk);            // inter-frame gap
   endtask

   task automatic wait_drained();
      while (exp_data.size() != 0) @(posedge clk);
   endtask

   initial begin : stimulus
      int   occupied;                       // predicted buffer words
      int   len;
      logic admit;
      seed              = 32'h207c2708;
      rdy_seed          = seed;
      errors            = 0;
      words_checked     = 0;
      exp_good          = 0;
      exp_bad           = 0;
      exp_dropped       = 0;
      reset             = 1'b1;
      gmac_rx_data      = '0;
      gmac_rx_dvld      = 1'b0;
      gmac_rx_goodframe = 1'b0;
      gmac_rx_badframe  = 1'b0;
      cfg_wr            = 1'b0;
      cfg_enable        = 1'b0;
      out_rdy           = 1'b1;
      rdy_random        = 1'b0;
      rdy_level         = 1'b1;
      test_name         = "reset";
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      test_name = "disabled_queue";        // enable is 0 out of reset
      repeat (3) send_frame(1 + rand_below(MAX_PKT_BYTES), 1'b1, 1'b0);
      write_enable(1'b1);

      test_name = "good_frames";
      send_frame(1, 1'b1, 1'b1);
      send_frame(8, 1'b1, 1'b1);
      send_frame(9, 1'b1, 1'b1);
      send_frame(MAX_PKT_BYTES, 1'b1, 1'b1);
      repeat (6) send_frame(1 + rand_below(MAX_PKT_BYTES), 1'b1, 1'b1);

      test_name = "bad_fcs";
      repeat (4) send_frame(1 + rand_below(MAX_PKT_BYTES), 1'b0, 1'b1);

      test_name = "oversize";
      repeat (3) send_frame(MAX_PKT_BYTES + 1 + rand_below(40), 1'b1, 1'b1);
      repeat (2) send_frame(1 + rand_below(MAX_PKT_BYTES), 1'b1, 1'b1);

      test_name  = "back_pressure";
      rdy_random = 1'b1;
      repeat (8) send_frame(1 + rand_below(MAX_PKT_BYTES), 1'b1, 1'b1);
      wait_drained();
      rdy_random = 1'b0;

      // sink stalled so the buffer only fills and admission follows the free words
      test_name = "buffer_full";
      rdy_level = 1'b0;
      occupied  = 0;
      repeat (8) begin
         len   = MAX_PKT_BYTES / 2 + rand_below(MAX_PKT_BYTES / 2 + 1);
         admit = (BUF_WORDS - occupied >= MAX_WORDS);
         if (admit) occupied += (len + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
         send_frame(len, 1'b1, admit);
      end
      rdy_level = 1'b1;
      wait_drained();
      repeat (4) @(posedge clk);            // last counter update

      check_count("good_count", cnt_t'(exp_good), good_cnt);
      check_count("bad_count", cnt_t'(exp_bad), bad_cnt);
      check_count("dropped_count", cnt_t'(exp_dropped), dropped_cnt);
      check_count("pulled_count", cnt_t'(exp_good), pulled_cnt);   // one per good frame

      $display("%0d words checked, %0d errors", words_checked, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // bound on the whole run
   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("timeout: run did not finish, %0d predicted words never came out",
               exp_data.size());
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/rx_queue.sv ====
// receive queue top level
// capture, word buffer, status queue, output engine, registers
`timescale 1ns/1ns
`default_nettype none

module rx_queue #(
   parameter int                      MAX_PKT_BYTES   = 256,
   parameter int                      BUF_DEPTH_BITS  = 7,
   parameter int                      STAT_DEPTH_BITS = 5,
   parameter rx_queue_pkg::port_num_t PORT_NUMBER     = '0,
   parameter rx_queue_pkg::ctrl_t     STAGE_NUMBER    = 8'hff
) (
   input  wire                        clk,
   input  wire                        reset,
   input  wire rx_queue_pkg::byte_t   gmac_rx_data,
   input  wire                        gmac_rx_dvld,
   input  wire                        gmac_rx_goodframe,
   input  wire                        gmac_rx_badframe,
   input  wire                        cfg_wr,
   input  wire                        cfg_enable,
   output wire rx_queue_pkg::word_t   out_data,
   output wire rx_queue_pkg::ctrl_t   out_ctrl,
   output wire                        out_wr,
   input  wire                        out_rdy,
   output wire rx_queue_pkg::cnt_t    good_cnt,
   output wire rx_queue_pkg::cnt_t    bad_cnt,
   output wire rx_queue_pkg::cnt_t    dropped_cnt,
   output wire rx_queue_pkg::cnt_t    pulled_cnt
);
   import rx_queue_pkg::*;

   logic                  buf_wr, buf_rd;
   word_t                 buf_wdata, buf_rdata;
   ctrl_t                 buf_wctrl, buf_rctrl;   // travel beside the data word
   logic [BUF_DEPTH_BITS:0] buf_used;
   logic                  stat_wr, stat_rd, stat_empty;
   status_t               stat_wdata, stat_rdata;
   logic                  rx_pkt_good, rx_pkt_bad, rx_pkt_dropped, rx_pkt_pulled;
   logic                  rx_queue_en;

   rx_mac_capture #(
      .MAX_PKT_BYTES  (MAX_PKT_BYTES),
      .BUF_DEPTH_BITS (BUF_DEPTH_BITS)
   ) capture (
      .clk (clk), .reset (reset),
      .gmac_rx_data (gmac_rx_data), .gmac_rx_dvld (gmac_rx_dvld),
      .gmac_rx_goodframe (gmac_rx_goodframe), .gmac_rx_badframe (gmac_rx_badframe),
      .rx_queue_en (rx_queue_en), .buf_used (buf_used),
      .buf_wr (buf_wr), .buf_wdata (buf_wdata), .buf_wctrl (buf_wctrl),
      .stat_wr (stat_wr), .stat_wdata (stat_wdata),
      .rx_pkt_good (rx_pkt_good), .rx_pkt_bad (rx_pkt_bad),
      .rx_pkt_dropped (rx_pkt_dropped)
   );

   // ctrl byte on top of the data word
   rx_sync_fifo #(
      .WIDTH      ($bits(ctrl_t) + $bits(word_t)),
      .DEPTH_BITS (BUF_DEPTH_BITS)
   ) word_buf (
      .clk (clk), .reset (reset), .wr (buf_wr), .rd (buf_rd),
      .wdata ({buf_wctrl, buf_wdata}), .rdata ({buf_rctrl, buf_rdata}),
      .empty (), .full (), .used (buf_used)
   );

   // one entry per admitted frame
   rx_sync_fifo #(
      .WIDTH      ($bits(status_t)),
      .DEPTH_BITS (STAT_DEPTH_BITS)
   ) stat_queue (
      .clk (clk), .reset (reset), .wr (stat_wr), .rd (stat_rd),
      .wdata (stat_wdata), .rdata (stat_rdata),
      .empty (stat_empty), .full (), .used ()
   );

   rx_output_ctrl #(
      .PORT_NUMBER  (PORT_NUMBER),
      .STAGE_NUMBER (STAGE_NUMBER)
   ) out_ctrl0 (
      .clk (clk), .reset (reset),
      .stat_rdata (stat_rdata), .stat_empty (stat_empty),
      .buf_rdata (buf_rdata), .buf_rctrl (buf_rctrl),
      .stat_rd (stat_rd), .buf_rd (buf_rd),
      .out_data (out_data), .out_ctrl (out_ctrl), .out_wr (out_wr),
      .out_rdy (out_rdy), .rx_pkt_pulled (rx_pkt_pulled)
   );

   rx_queue_regs regs (
      .clk (clk), .reset (reset), .cfg_wr (cfg_wr), .cfg_enable (cfg_enable),
      .rx_pkt_good (rx_pkt_good), .rx_pkt_bad (rx_pkt_bad),
      .rx_pkt_dropped (rx_pkt_dropped), .rx_pkt_pulled (rx_pkt_pulled),
      .rx_queue_en (rx_queue_en),
      .good_cnt (good_cnt), .bad_cnt (bad_cnt),
      .dropped_cnt (dropped_cnt), .pulled_cnt (pulled_cnt)
   );

endmodule

`default_nettype wire

// ==== verilog/rx_queue_regs.sv ====
// enable register and saturating frame counters
`timescale 1ns/1ns
`default_nettype none

module rx_queue_regs (
   input  wire                 clk,
   input  wire                 reset,
   input  wire                 cfg_wr,
   input  wire                 cfg_enable,
   input  wire                 rx_pkt_good,
   input  wire                 rx_pkt_bad,
   input  wire                 rx_pkt_dropped,
   input  wire                 rx_pkt_pulled,
   output logic                rx_queue_en,
   output rx_queue_pkg::cnt_t  good_cnt,
   output rx_queue_pkg::cnt_t  bad_cnt,
   output rx_queue_pkg::cnt_t  dropped_cnt,
   output rx_queue_pkg::cnt_t  pulled_cnt
);
   import rx_queue_pkg::*;

   logic [3:0] pulse;
   cnt_t       cnt [4];

   assign pulse = {rx_pkt_pulled, rx_pkt_dropped, rx_pkt_bad, rx_pkt_good};

   always_ff @(posedge clk) begin
      if (reset) rx_queue_en <= 1'b0;       // queue starts disabled
      else if (cfg_wr) rx_queue_en <= cfg_enable;
   end

   // stick at all ones
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (reset) cnt[i] <= '0;
         else if (pulse[i] && cnt[i] != '1) cnt[i] <= cnt[i] + 1'b1;
      end
   end

   assign good_cnt    = cnt[0];
   assign bad_cnt     = cnt[1];
   assign dropped_cnt = cnt[2];
   assign pulled_cnt  = cnt[3];

endmodule

`default_nettype wire

// ==== verilog/rx_output_ctrl.sv ====
// output engine of the receive queue
// header build, forwarding of good frames, draining of bad ones
`timescale 1ns/1ns
`default_nettype none

module rx_output_ctrl #(
   parameter rx_queue_pkg::port_num_t PORT_NUMBER  = '0,
   parameter rx_queue_pkg::ctrl_t     STAGE_NUMBER = 8'hff
) (
   input  wire                         clk,
   input  wire                         reset,
   input  wire rx_queue_pkg::status_t  stat_rdata,
   input  wire                         stat_empty,
   input  wire rx_queue_pkg::word_t    buf_rdata,
   input  wire rx_queue_pkg::ctrl_t    buf_rctrl,
   output logic                        stat_rd,
   output logic                        buf_rd,
   output rx_queue_pkg::word_t         out_data,
   output rx_queue_pkg::ctrl_t         out_ctrl,
   output logic                        out_wr,
   input  wire                         out_rdy,
   output logic                        rx_pkt_pulled
);
   import rx_queue_pkg::*;
   import rx_fsm_pkg::*;

   localparam int GOOD_BIT = $bits(pkt_len_t);  // status flag above the length

   out_state_t state;
   out_state_t state_nxt;
   logic       pkt_good;     // status of the frame in flight
   pkt_len_t   pkt_len;
   pkt_len_t   word_len;
   word_t      header;
   logic       send_hdr;
   logic       out_wr_nxt;
   logic       pulled_nxt;

   // bytes rounded up to whole words
   assign word_len = (pkt_len >> LANE_BITS) + pkt_len_t'(|pkt_len[LANE_BITS-1:0]);

   always_comb begin
      header = '0;
      header[HDR_WORD_LEN_POS +: $bits(pkt_len_t)]  = word_len;
      header[HDR_SRC_PORT_POS +: $bits(port_num_t)] = PORT_NUMBER;
      header[HDR_BYTE_LEN_POS +: $bits(pkt_len_t)]  = pkt_len;
   end

   // ========================================================================
   // output FSM
   // ========================================================================
   always_comb begin
      state_nxt  = state;
      stat_rd    = 1'b0;
      buf_rd     = 1'b0;
      send_hdr   = 1'b0;
      out_wr_nxt = 1'b0;
      pulled_nxt = 1'b0;

      case (state)
         OUT_WAIT_PKT: begin
            if (!stat_empty) begin
               stat_rd   = 1'b1;
               state_nxt = stat_rdata[GOOD_BIT] ? OUT_HEADER : OUT_DATA;  // bad skips header
            end
         end
         OUT_HEADER: begin
            send_hdr = 1'b1;
            if (out_rdy) begin
               out_wr_nxt = 1'b1;
               state_nxt  = OUT_DATA;
            end
         end
         OUT_DATA: begin
            // bad frames drain one word per cycle regardless of out_rdy
            if (out_rdy || !pkt_good) begin
               buf_rd     = 1'b1;
               out_wr_nxt = pkt_good;
               if (|buf_rctrl) begin      // last word of the frame
                  pulled_nxt = pkt_good;
                  state_nxt  = OUT_WAIT_PKT;
               end
            end
         end
         default: state_nxt = OUT_WAIT_PKT;
      endcase
   end

   always_ff @(posedge clk) begin
      if (stat_rd) begin
         pkt_good <= stat_rdata[GOOD_BIT];
         pkt_len  <= stat_rdata[GOOD_BIT-1:0];
      end
      out_data <= send_hdr ? header : buf_rdata;
      out_ctrl <= send_hdr ? STAGE_NUMBER : buf_rctrl;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state         <= OUT_WAIT_PKT;
         out_wr        <= 1'b0;
         rx_pkt_pulled <= 1'b0;
      end else begin
         state         <= state_nxt;
         out_wr        <= out_wr_nxt;
         rx_pkt_pulled <= pulled_nxt;   // lines up with the last out_wr
      end
   end

endmodule

`default_nettype wire

// ==== verilog/rx_mac_capture.sv ====
// mac side of the receive queue
// byte packer, admission check, status writer
`timescale 1ns/1ns
`default_nettype none

module rx_mac_capture #(
   parameter int MAX_PKT_BYTES  = 256,
   parameter int BUF_DEPTH_BITS = 7
) (
   input  wire                        clk,
   input  wire                        reset,
   input  wire rx_queue_pkg::byte_t   gmac_rx_data,
   input  wire                        gmac_rx_dvld,
   input  wire                        gmac_rx_goodframe,
   input  wire                        gmac_rx_badframe,
   input  wire                        rx_queue_en,
   input  wire [BUF_DEPTH_BITS:0]     buf_used,
   output logic                       buf_wr,
   output rx_queue_pkg::word_t        buf_wdata,
   output rx_queue_pkg::ctrl_t        buf_wctrl,
   output logic                       stat_wr,
   output rx_queue_pkg::status_t      stat_wdata,
   output logic                       rx_pkt_good,
   output logic                       rx_pkt_bad,
   output logic                       rx_pkt_dropped
);
   import rx_queue_pkg::*;
   import rx_fsm_pkg::*;

   localparam int BUF_WORDS = 2 ** BUF_DEPTH_BITS;
   localparam int MAX_WORDS = MAX_PKT_BYTES / BYTES_PER_WORD;

   rx_state_t            state;
   rx_state_t            state_nxt;
   byte_t                data_d1;     // input register
   logic                 dvld_d1;
   pkt_len_t             byte_cnt;    // bytes taken so far
   pkt_len_t             byte_inc;
   logic [LANE_BITS-1:0] lane;        // lane of the byte in data_d1, 0 = msb
   word_t                word_reg;
   word_t                word_nxt;
   logic                 room;
   logic                 shift;       // take data_d1 into the word
   logic                 wr_nxt;
   logic                 last_nxt;
   logic                 frame_good;
   pkt_len_t             stat_len;

   assign byte_inc = byte_cnt + 1'b1;
   assign lane     = byte_cnt[LANE_BITS-1:0];
   assign room     = (buf_used <= BUF_WORDS - MAX_WORDS);  // space for a max frame

   // msb lane first, a new word starts from zero so the tail is padded
   always_comb begin
      word_nxt = (lane == '0) ? '0 : word_reg;
      word_nxt[(BYTES_PER_WORD - 1 - lane) * 8 +: 8] = data_d1;
   end

   // ========================================================================
   // frame FSM
   // ========================================================================
   always_comb begin
      state_nxt      = state;
      shift          = 1'b0;
      wr_nxt         = 1'b0;
      last_nxt       = 1'b0;
      stat_wr        = 1'b0;
      frame_good     = 1'b0;
      stat_len       = byte_cnt;
      rx_pkt_dropped = 1'b0;

      case (state)
         RX_IDLE: begin
            if (dvld_d1 && !(rx_queue_en && room)) begin
               rx_pkt_dropped = 1'b1;       // whole frame goes
               state_nxt      = RX_DISCARD;
            end else if (dvld_d1) begin
               shift     = 1'b1;
               state_nxt = RX_RECEIVE;
            end
         end
         RX_RECEIVE: shift = 1'b1;          // dvld_d1 is high throughout
         RX_WAIT_FCS: begin
            if (gmac_rx_goodframe || gmac_rx_badframe) begin
               stat_wr    = 1'b1;
               frame_good = gmac_rx_goodframe;
               state_nxt  = RX_IDLE;
            end
         end
         RX_DISCARD: begin
            if (!dvld_d1) state_nxt = RX_IDLE;  // late fcs pulse lands in idle
         end
         default: state_nxt = RX_IDLE;
      endcase

      // raw dvld low means data_d1 holds the last byte
      if (shift) begin
         if (!gmac_rx_dvld) begin
            wr_nxt    = 1'b1;
            last_nxt  = 1'b1;
            state_nxt = RX_WAIT_FCS;
         end else if (byte_inc == pkt_len_t'(MAX_PKT_BYTES)) begin
            wr_nxt    = 1'b1;               // cut off, counted bad right away
            last_nxt  = 1'b1;
            stat_wr   = 1'b1;
            stat_len  = byte_inc;
            state_nxt = RX_DISCARD;
         end else begin
            wr_nxt = (lane == '1);          // full word
         end
      end
   end

   assign stat_wdata  = {frame_good, stat_len};
   assign rx_pkt_good = stat_wr && frame_good;
   assign rx_pkt_bad  = stat_wr && !frame_good;

   // data path
   always_ff @(posedge clk) begin
      data_d1 <= gmac_rx_data;
      if (shift) word_reg <= word_nxt;
      if (wr_nxt) begin
         buf_wdata <= word_nxt;
         // marker bit sits at the lane of the last valid byte
         buf_wctrl <= last_nxt ? (ctrl_t'(1) << (BYTES_PER_WORD - 1 - lane)) : '0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= RX_IDLE;
         dvld_d1  <= 1'b0;
         byte_cnt <= '0;
         buf_wr   <= 1'b0;
      end else begin
         state   <= state_nxt;
         dvld_d1 <= gmac_rx_dvld;
         buf_wr  <= wr_nxt;
         if (shift) byte_cnt <= byte_inc;
         else if (state != RX_WAIT_FCS) byte_cnt <= '0;  // held for the status entry
      end
   end

   // mac gives one verdict per frame
   a_one_verdict: assert property (@(posedge clk) disable iff (reset)
      !(gmac_rx_goodframe && gmac_rx_badframe));

endmodule

`default_nettype wire

// ==== verilog/rx_sync_fifo.sv ====
// show-ahead synchronous fifo with used-word count
`timescale 1ns/1ns
`default_nettype none

module rx_sync_fifo #(
   parameter int WIDTH      = 72,
   parameter int DEPTH_BITS = 7
) (
   input  wire                   clk,
   input  wire                   reset,
   input  wire                   wr,
   input  wire                   rd,
   input  wire [WIDTH-1:0]       wdata,
   output logic [WIDTH-1:0]      rdata,
   output logic                  empty,
   output logic                  full,
   output logic [DEPTH_BITS:0]   used
);

   localparam int DEPTH = 2 ** DEPTH_BITS;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_BITS-1:0] wr_ptr;
   logic [DEPTH_BITS-1:0] rd_ptr;
   logic [DEPTH_BITS:0]   count;   // one extra bit so full is representable

   assign rdata = mem[rd_ptr];    // head word, no read latency
   assign empty = (count == '0);
   assign full  = count[DEPTH_BITS];
   assign used  = count;

   always_ff @(posedge clk) begin
      if (wr) mem[wr_ptr] <= wdata;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap naturally
         if (rd) rd_ptr <= rd_ptr + 1'b1;
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // writers and readers keep to the flags
   a_no_overflow: assert property (@(posedge clk) disable iff (reset) wr |-> !full);
   a_no_underflow: assert property (@(posedge clk) disable iff (reset) rd |-> !empty);

endmodule

`default_nettype wire

// ==== verilog/rx_fsm_pkg.sv ====
// state encodings of the receive queue
// capture FSM and output FSM
`default_nettype none

package rx_fsm_pkg;

   typedef enum logic [1:0] {
      RX_IDLE,      // wait for first byte, admission check
      RX_RECEIVE,   // packing bytes into words
      RX_WAIT_FCS,  // frame done, fcs verdict pending
      RX_DISCARD    // dropped or cut off, skip the rest
   } rx_state_t;

   typedef enum logic [1:0] {
      OUT_WAIT_PKT,  // wait for a status entry
      OUT_HEADER,    // module header word
      OUT_DATA       // forward or drain data words
   } out_state_t;

endpackage

`default_nettype wire

// ==== verilog/rx_queue_pkg.sv ====
// data formats of the receive queue
// word, control, byte and length types, header field positions
`default_nettype none

package rx_queue_pkg;

   typedef logic [7:0]  byte_t;      // one mac byte
   typedef logic [63:0] word_t;      // output data word
   typedef logic [7:0]  ctrl_t;      // one bit per byte lane, bit 0 = lsb lane
   typedef logic [15:0] pkt_len_t;   // bytes or words
   typedef logic [15:0] port_num_t;  // source port field
   typedef logic [15:0] cnt_t;       // statistics counter
   typedef logic [16:0] status_t;    // {good, byte length}

   localparam int BYTES_PER_WORD = 8;
   localparam int LANE_BITS      = 3;  // log2 of bytes per word

   // header word layout
   localparam int HDR_WORD_LEN_POS = 48;  // length in words, rounded up
   localparam int HDR_SRC_PORT_POS = 32;
   localparam int HDR_BYTE_LEN_POS = 0;   // length in bytes

endpackage

`default_nettype wire
